/* Makefile */
# Verilator build and run for the decode stage testbench.

VERILATOR ?= verilator
TOP       ?= decode_stage_tb
FILE_LIST ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps
PASS_MSG  ?= Done: no errors

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv src/*.svh bench/*.sv)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)" || { echo "Simulation failed"; exit 1; }

clean:
	rm -rf $(OBJ_DIR)

/* bench/decode_stage_asserts.sv */
`timescale 1ns/10ps

module decode_stage_asserts (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   stall,
    input logic                   flush,
    input logic                   out_valid,
    input stage_pkg::decode_pkt_t out_pkt
);

    int unsigned fail_count = 0; // Read by the testbench.

    // ****************************************
    // Protocol properties
    // ****************************************

    property reset_idle;
        @(posedge clk) !rst_n |=> !out_valid;
    endproperty

    // A valid packet must not move while stalled.
    property stall_holds_pkt;
        @(posedge clk) disable iff (!rst_n)
            (stall && !flush && out_valid) |=> $stable(out_pkt);
    endproperty

    property flush_drops_valid;
        @(posedge clk) disable iff (!rst_n) flush |=> !out_valid;
    endproperty

    a_reset_idle: assert property (reset_idle) else begin
        fail_count++;
        $error("out_valid high after reset edge");
    end

    a_stall_hold: assert property (stall_holds_pkt) else begin
        fail_count++;
        $error("out_pkt changed during stall");
    end

    a_flush_drop: assert property (flush_drops_valid) else begin
        fail_count++;
        $error("out_valid high after flush");
    end

endmodule

bind decode_stage decode_stage_asserts u_asserts (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall    (stall),
    .flush    (flush),
    .out_valid(out_valid),
    .out_pkt  (out_pkt)
);

/* bench/decode_stage_tb.sv */
`timescale 1ns/10ps
`include "core_settings.svh"

module decode_stage_tb;

    import isa_pkg::*;
    import stage_pkg::*;

    localparam int CLK_PERIOD      = 8;
    localparam int RESET_CYCLES    = 10;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 600;
    localparam int WATCHDOG_NS     = (RESET_CYCLES + NUM_TESTS * CYCLES_PER_TEST) * CLK_PERIOD;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    word_t       in_pc;
    word_t       in_instr;
    logic        stall;
    logic        flush;
    logic        wb_en;
    regaddr_t    wb_addr;
    word_t       wb_data;
    logic        out_valid;
    decode_pkt_t out_pkt;
    word_t       model_regs [`REG_COUNT]; // Architectural state as the bench sees it.

    decode_stage uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_pc    (in_pc),
        .in_instr (in_instr),
        .stall    (stall),
        .flush    (flush),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data),
        .out_valid(out_valid),
        .out_pkt  (out_pkt)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ****************************************
    // Reference model
    // ****************************************

    function automatic word_t reg_value(regaddr_t addr, logic fwd_en, regaddr_t fwd_addr,
                                        word_t fwd_data);
        word_t value;
        value = model_regs[addr];
        if (fwd_en && fwd_addr == addr) begin
            value = fwd_data; // Same-cycle writeback wins.
        end
        if (addr == '0) begin
            value = '0;
        end
        return value;
    endfunction

    function automatic decode_pkt_t expected_pkt(word_t pc, word_t instr, logic fwd_en,
                                                 regaddr_t fwd_addr, word_t fwd_data);
        decode_pkt_t   p;
        control_word_t c;
        logic [2:0]    f3;
        f3 = instr[14:12];
        c = '0;
        c.alu_mode = ALU_X;
        c.ma_size = MA_SIZE_X;
        p.imm = '0;
        case (instr[6:0])
            OP: begin
                c.alu_op1 = ALU_OP1_RS1;
                c.alu_op2 = ALU_OP2_RS2;
                c.alu_mode = alu_mode_t'({instr[30], f3});
                c.wb_src = WB_SRC_ALU;
                c.ra_used = 1'b1;
                c.rb_used = 1'b1;
            end
            OP_IMM: begin
                c.alu_op1 = ALU_OP1_RS1;
                c.alu_op2 = ALU_OP2_IMMI;
                c.alu_mode = alu_mode_t'({instr[30] && f3[1:0] == 2'b01, f3}); // Shifts only.
                c.wb_src = WB_SRC_ALU;
                c.ra_used = 1'b1;
                p.imm = $signed({instr[31:20], 20'b0}) >>> 20;
            end
            OP_LUI, OP_AUIPC: begin
                c.alu_op1 = ALU_OP1_IMMU;
                c.alu_op2 = (instr[5:4] == 2'b01) ? ALU_OP2_PC : ALU_OP2_X;
                c.alu_mode = (instr[5:4] == 2'b01) ? ALU_ADD : ALU_COPY1;
                c.wb_src = WB_SRC_ALU;
                p.imm = {instr[31:12], 12'b0};
            end
            OP_JAL: begin
                c.pc_mode = PC_JUMP_REL;
                c.wb_src = WB_SRC_PC4;
                p.imm = $signed({instr[31], instr[19:12], instr[20], instr[30:21], 12'b0}) >>> 11;
            end
            OP_JALR: begin
                c.pc_mode = PC_JUMP_ABS;
                c.wb_src = WB_SRC_PC4;
                c.ra_used = 1'b1;
                p.imm = $signed({instr[31:20], 20'b0}) >>> 20;
            end
            OP_BRANCH: begin
                c.halt = (f3 == 3'b010 || f3 == 3'b011);
                c.pc_mode = c.halt ? PC_NEXT : PC_BRANCH;
                c.ra_used = !c.halt;
                c.rb_used = !c.halt;
                p.imm = $signed({instr[31], instr[7], instr[30:25], instr[11:8], 20'b0}) >>> 19;
            end
            OP_LOAD: begin
                c.alu_op1 = ALU_OP1_RS1;
                c.alu_op2 = ALU_OP2_IMMI;
                c.alu_mode = ALU_ADD;
                c.ma_mode = MA_LOAD;
                c.ma_size = ma_size_t'(f3);
                c.wb_src = WB_SRC_MEM;
                c.ra_used = 1'b1;
                p.imm = $signed({instr[31:20], 20'b0}) >>> 20;
            end
            OP_STORE: begin
                c.alu_op1 = ALU_OP1_RS1;
                c.alu_op2 = ALU_OP2_IMMS;
                c.alu_mode = ALU_ADD;
                c.ma_mode = MA_STORE;
                c.ma_size = ma_size_t'(f3);
                c.ra_used = 1'b1;
                c.rb_used = 1'b1;
                p.imm = $signed({instr[31:25], instr[11:7], 20'b0}) >>> 20;
            end
            OP_MISC_MEM: begin
                c.halt = 1'b0; // Fences do nothing here.
            end
            OP_SYSTEM: begin
                c.priv = (f3 == 3'b000);
                c.halt = (f3 == 3'b100);
                c.csr_used = !c.priv && !c.halt;
                c.ra_used = c.csr_used && !f3[2]; // Register forms read rs1.
                p.imm = $signed({instr[31:20], 20'b0}) >>> 20;
            end
            default: c.halt = 1'b1;
        endcase
        c.ra_used = c.ra_used && instr[19:15] != '0;
        c.rb_used = c.rb_used && instr[24:20] != '0;
        c.wb_valid = c.wb_src != WB_SRC_X && instr[11:7] != '0;
        p.pc = pc;
        p.cw = c;
        p.rs1_data = reg_value(instr[19:15], fwd_en, fwd_addr, fwd_data);
        p.rs2_data = reg_value(instr[24:20], fwd_en, fwd_addr, fwd_data);
        p.rd = instr[11:7];
        return p;
    endfunction

    // ****************************************
    // Drivers and checks
    // ****************************************

    task automatic check_bit(string name, logic exp, logic act);
        assert (act === exp) else begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            $display("Done: errors found");
            $fatal(1, "Valid mismatch in %s", name);
        end
    endtask

    task automatic check_pkt(string name, decode_pkt_t exp);
        assert (out_pkt === exp) else begin
            $display("ERR %s expected %h actual %h", name, exp, out_pkt);
            $display("Done: errors found");
            $fatal(1, "Packet mismatch in %s", name);
        end
    endtask

    task automatic write_reg(regaddr_t addr, word_t data);
        @(negedge clk);
        wb_en = 1'b1;
        wb_addr = addr;
        wb_data = data;
        @(negedge clk);
        wb_en = 1'b0;
        if (addr != '0) begin
            model_regs[addr] = data;
        end
    endtask

    // One instruction through the stage with an optional writeback in its decode cycle.
    task automatic run_instr(string name, word_t pc, word_t instr, logic fwd_en,
                             regaddr_t fwd_addr, word_t fwd_data);
        decode_pkt_t exp;
        @(negedge clk);
        in_valid = 1'b1;
        in_pc = pc;
        in_instr = instr;
        @(negedge clk);
        in_valid = 1'b0;
        wb_en = fwd_en;
        wb_addr = fwd_addr;
        wb_data = fwd_data;
        exp = expected_pkt(pc, instr, fwd_en, fwd_addr, fwd_data);
        check_bit({name, " latency"}, 1'b0, out_valid);
        @(negedge clk);
        wb_en = 1'b0;
        if (fwd_en && fwd_addr != '0) begin
            model_regs[fwd_addr] = fwd_data;
        end
        check_bit({name, " valid"}, 1'b1, out_valid);
        check_pkt(name, exp);
    endtask

    // ****************************************
    // Directed tests
    // ****************************************

    task automatic test_alu_ops();
        word_t instr;
        for (int r = 1; r < `REG_COUNT; r++) begin
            write_reg(regaddr_t'(r), $urandom);
        end
        for (int i = 0; i < 24; i++) begin
            instr = $urandom;
            if (i % 2 == 0) begin
                instr[6:0] = OP;
                instr[31:25] = {1'b0, instr[30], 5'b0};
            end else begin
                instr[6:0] = OP_IMM; // Random funct7 covers the bit 3 rule.
            end
            run_instr("alu_ops", $urandom & 32'hffff_fffc, instr, 1'b0, '0, '0);
        end
    endtask

    task automatic test_mem_upper();
        word_t      instr;
        logic [2:0] f3;
        for (int i = 0; i < 20; i++) begin
            instr = $urandom;
            case (i % 4)
                0: begin
                    f3 = 3'($urandom_range(0, 4));
                    if (f3 > 3'd2) begin
                        f3 += 3'd1; // Skips the unused 011.
                    end
                    instr[14:12] = f3;
                    instr[6:0] = OP_LOAD;
                end
                1: begin
                    instr[14:12] = 3'($urandom_range(0, 2));
                    instr[6:0] = OP_STORE;
                end
                2: instr[6:0] = OP_LUI;
                default: instr[6:0] = OP_AUIPC;
            endcase
            run_instr("mem_upper", $urandom & 32'hffff_fffc, instr, 1'b0, '0, '0);
        end
    endtask

    task automatic test_control_flow();
        word_t      instr;
        logic [2:0] f3;
        for (int i = 0; i < 18; i++) begin
            instr = $urandom;
            f3 = 3'($urandom_range(0, 5));
            if (f3 > 3'd1) begin
                f3 += 3'd2; // Legal branch conditions only.
            end
            case (i % 3)
                0: begin
                    instr[14:12] = f3;
                    instr[6:0] = OP_BRANCH;
                end
                1: instr[6:0] = OP_JAL;
                default: begin
                    instr[14:12] = 3'b000;
                    instr[6:0] = OP_JALR;
                end
            endcase
            run_instr("control_flow", $urandom & 32'hffff_fffc, instr, 1'b0, '0, '0);
        end
    endtask

    task automatic test_illegal_system();
        word_t instr;
        for (int op = 0; op < 128; op++) begin
            instr = $urandom;
            instr[6:0] = 7'(op);
            run_instr("opcode_sweep", $urandom & 32'hffff_fffc, instr, 1'b0, '0, '0);
        end
        for (int f = 0; f < 8; f++) begin
            instr = $urandom;
            instr[14:12] = 3'(f);
            instr[6:0] = OP_SYSTEM;
            run_instr("system_funct3", $urandom & 32'hffff_fffc, instr, 1'b0, '0, '0);
        end
        for (int f = 2; f < 4; f++) begin
            instr = $urandom;
            instr[14:12] = 3'(f);
            instr[6:0] = OP_BRANCH;
            run_instr("branch_illegal", $urandom & 32'hffff_fffc, instr, 1'b0, '0, '0);
        end
    endtask

    task automatic test_reg_file();
        write_reg(5'd5, 32'h1234_5678);
        run_instr("forward_rs1", 32'h100, {7'b0, 5'd6, 5'd5, 3'b000, 5'd7, OP}, 1'b1, 5'd5,
                  $urandom);
        run_instr("forward_both", 32'h104, {7'b0, 5'd9, 5'd9, 3'b000, 5'd7, OP}, 1'b1, 5'd9,
                  $urandom);
        run_instr("after_forward", 32'h108, {7'b0, 5'd9, 5'd5, 3'b000, 5'd7, OP}, 1'b0, '0, '0);
        write_reg(5'd0, $urandom);
        run_instr("x0_read", 32'h10c, {7'b0, 5'd0, 5'd0, 3'b000, 5'd1, OP}, 1'b0, '0, '0);
        run_instr("x0_forward", 32'h110, {7'b0, 5'd0, 5'd0, 3'b000, 5'd0, OP}, 1'b1, 5'd0,
                  $urandom);
    endtask

    task automatic test_stall_flush();
        word_t       instr;
        word_t       held_instr;
        decode_pkt_t exp;
        instr = $urandom;
        instr[6:0] = OP_IMM;
        exp = expected_pkt(32'h200, instr, 1'b0, '0, '0);
        @(negedge clk);
        in_valid = 1'b1;
        in_pc = 32'h200;
        in_instr = instr;
        @(negedge clk);
        in_valid = 1'b0;
        stall = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_bit("stall_delay", 1'b0, out_valid);
        end
        stall = 1'b0;
        @(negedge clk);
        check_bit("stall_delay valid", 1'b1, out_valid);
        check_pkt("stall_delay", exp);

        // Output held while the producer keeps its next instruction ready.
        held_instr = $urandom;
        held_instr[6:0] = OP;
        stall = 1'b1;
        in_valid = 1'b1;
        in_pc = 32'h204;
        in_instr = held_instr;
        repeat (3) begin
            @(negedge clk);
            check_bit("stall_hold valid", 1'b1, out_valid);
            check_pkt("stall_hold", exp);
        end
        stall = 1'b0;
        @(negedge clk);
        in_valid = 1'b0;
        check_bit("stall_release", 1'b0, out_valid);
        @(negedge clk);
        check_bit("stall_release valid", 1'b1, out_valid);
        check_pkt("stall_release", expected_pkt(32'h204, held_instr, 1'b0, '0, '0));

        // Both instructions in flight get dropped.
        @(negedge clk);
        in_valid = 1'b1;
        in_pc = 32'h300;
        in_instr = instr;
        @(negedge clk);
        in_pc = 32'h304;
        in_instr = held_instr;
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        in_valid = 1'b0;
        check_bit("flush", 1'b0, out_valid);
        check_pkt("flush", expected_pkt('0, `NOP_INSTR, 1'b0, '0, '0));
        repeat (4) begin
            @(negedge clk);
            check_bit("flush_drain", 1'b0, out_valid);
        end
    endtask

    // ****************************************
    // Main sequence and watchdog
    // ****************************************

    initial begin
        void'($urandom(32'h887));
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_pc = '0;
        in_instr = `NOP_INSTR;
        stall = 1'b0;
        flush = 1'b0;
        wb_en = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        model_regs = '{default: '0};
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        check_bit("reset", 1'b0, out_valid);
        run_instr("reset_regs", 32'h0, {7'b0, 5'd4, 5'd3, 3'b000, 5'd1, OP}, 1'b0, '0, '0);
        test_alu_ops();
        test_mem_upper();
        test_control_flow();
        test_illegal_system();
        test_reg_file();
        test_stall_flush();
        if (uut.u_asserts.fail_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Protocol assertions failed %0d times", uut.u_asserts.fail_count);
            $display("Done: errors found");
            $fatal(1, "Protocol assertion failure");
        end
    end

    // Bound protocol checker failures end the run at once.
    always @(negedge clk) begin
        assert (uut.u_asserts.fail_count == 0) else begin
            $display("A protocol assertion on the DUT failed");
            $display("Done: errors found");
            $fatal(1, "Protocol assertion failure");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests completed");
        $display("Done: errors found");
        $fatal(1, "Timeout");
    end

endmodule

/* src/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// ****************************************
// Core sizing
// ****************************************

// Data and instruction width.
`define XLEN 32

// Architectural register count, x0 included.
`define REG_COUNT 32
`define REG_ADDR_W 5

// ****************************************
// Canonical encodings
// ****************************************

`define NOP_INSTR 32'h0000_0013 // addi x0, x0, 0.

`endif

/* src/decode_stage.sv */
`timescale 1ns/10ps

module decode_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  isa_pkg::word_t        in_pc,
    input  isa_pkg::word_t        in_instr,
    input  logic                  stall,
    input  logic                  flush,
    input  logic                  wb_en,
    input  isa_pkg::regaddr_t     wb_addr,
    input  isa_pkg::word_t        wb_data,
    output logic                  out_valid,
    output stage_pkg::decode_pkt_t out_pkt
);

    import isa_pkg::*;
    import stage_pkg::*;

    fetch_pkt_t    fetch_in;
    fetch_pkt_t    fetch_q;
    logic          fetch_valid;
    control_word_t cw;
    word_t         imm;
    word_t         rs1_data;
    word_t         rs2_data;
    decode_pkt_t   decode_in;

    assign fetch_in = '{pc: in_pc, instr: in_instr};

    // ****************************************
    // Fetch side register
    // ****************************************

    pipe_reg #(
        .payload_t  (fetch_pkt_t),
        .FLUSH_VALUE(FETCH_NOP)
    ) fetch_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .flush    (flush),
        .in_valid (in_valid),
        .in_data  (fetch_in),
        .out_valid(fetch_valid),
        .out_data (fetch_q)
    );

    // ****************************************
    // Decode, immediate and operand read
    // ****************************************

    decoder u_decoder (.instr(fetch_q.instr), .cw(cw));

    imm_gen u_imm_gen (.instr(fetch_q.instr), .imm(imm));

    reg_file u_reg_file (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs1_addr(fetch_q.instr[19:15]),
        .rs2_addr(fetch_q.instr[24:20]),
        .rs1_data(rs1_data),
        .rs2_data(rs2_data),
        .wb_en   (wb_en),
        .wb_addr (wb_addr),
        .wb_data (wb_data)
    );

    always_comb begin
        decode_in.pc       = fetch_q.pc;
        decode_in.cw       = cw;
        decode_in.rs1_data = rs1_data;
        decode_in.rs2_data = rs2_data;
        decode_in.imm      = imm;
        decode_in.rd       = fetch_q.instr[11:7];
    end

    // Valid tag follows the fetch register.
    pipe_reg #(
        .payload_t  (decode_pkt_t),
        .FLUSH_VALUE(DECODE_NOP)
    ) decode_reg (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .flush    (flush),
        .in_valid (fetch_valid),
        .in_data  (decode_in),
        .out_valid(out_valid),
        .out_data (out_pkt)
    );

endmodule

/* src/decoder.sv */
`timescale 1ns/10ps

module decoder (
    input  isa_pkg::word_t         instr,
    output isa_pkg::control_word_t cw
);

    import isa_pkg::*;

    // Everything unused, nothing written back.
    localparam control_word_t CW_BASE = '{
        halt: 1'b0, pc_mode: PC_NEXT, alu_op1: ALU_OP1_X, alu_op2: ALU_OP2_X,
        alu_mode: ALU_X, ma_mode: MA_X, ma_size: MA_SIZE_X, wb_src: WB_SRC_X,
        wb_valid: 1'b0, ra_used: 1'b0, rb_used: 1'b0, csr_used: 1'b0, priv: 1'b0
    };

    opcode_t       opcode;
    regaddr_t      rd;
    regaddr_t      rs1;
    regaddr_t      rs2;
    funct3_t       f3;
    funct7_t       f7;
    alu_mode_t     alu_mode;
    control_word_t cw_r;

    // ****************************************
    // Field unpacking
    // ****************************************

    always_comb begin
        opcode   = opcode_t'(instr[6:0]);
        rd       = instr[11:7];
        f3       = instr[14:12];
        rs1      = instr[19:15];
        rs2      = instr[24:20];
        f7       = instr[31:25];
        alu_mode = alu_mode_t'({f7[5], f3});
    end

    // ****************************************
    // Control table
    // ****************************************

    always_comb begin
        cw_r = CW_BASE;
        case (opcode)
            OP_IMM, OP: begin
                cw_r.alu_op1  = ALU_OP1_RS1;
                cw_r.alu_op2  = (opcode == OP) ? ALU_OP2_RS2 : ALU_OP2_IMMI;
                cw_r.alu_mode = alu_mode;
                cw_r.wb_src   = WB_SRC_ALU;
                cw_r.ra_used  = 1'b1;
                cw_r.rb_used  = (opcode == OP);
            end
            OP_LUI, OP_AUIPC: begin
                cw_r.alu_op1  = ALU_OP1_IMMU;
                cw_r.alu_op2  = (opcode == OP_AUIPC) ? ALU_OP2_PC : ALU_OP2_X;
                cw_r.alu_mode = (opcode == OP_AUIPC) ? ALU_ADD : ALU_COPY1;
                cw_r.wb_src   = WB_SRC_ALU;
            end
            OP_JAL: begin
                cw_r.pc_mode = PC_JUMP_REL;
                cw_r.wb_src  = WB_SRC_PC4;
            end
            OP_JALR: begin
                cw_r.pc_mode = PC_JUMP_ABS;
                cw_r.wb_src  = WB_SRC_PC4;
                cw_r.ra_used = 1'b1; // Base address.
            end
            OP_BRANCH: begin
                case (f3)
                    F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU: begin
                        cw_r.pc_mode = PC_BRANCH;
                        cw_r.ra_used = 1'b1;
                        cw_r.rb_used = 1'b1;
                    end
                    default: cw_r.halt = 1'b1;
                endcase
            end
            OP_LOAD, OP_STORE: begin
                // Address is always rs1 plus offset.
                cw_r.alu_op1  = ALU_OP1_RS1;
                cw_r.alu_op2  = (opcode == OP_LOAD) ? ALU_OP2_IMMI : ALU_OP2_IMMS;
                cw_r.alu_mode = ALU_ADD;
                cw_r.ma_mode  = (opcode == OP_LOAD) ? MA_LOAD : MA_STORE;
                cw_r.ma_size  = ma_size_t'(f3);
                cw_r.wb_src   = (opcode == OP_LOAD) ? WB_SRC_MEM : WB_SRC_X;
                cw_r.ra_used  = 1'b1;
                cw_r.rb_used  = (opcode == OP_STORE);
            end
            OP_MISC_MEM: cw_r = CW_BASE; // Fences act as no-ops here.
            OP_SYSTEM: begin
                case (f3)
                    F3_PRIV: cw_r.priv = 1'b1;
                    F3_CSRRW, F3_CSRRS, F3_CSRRC: begin
                        cw_r.csr_used = 1'b1;
                        cw_r.ra_used  = 1'b1;
                    end
                    F3_CSRRWI, F3_CSRRSI, F3_CSRRCI: cw_r.csr_used = 1'b1;
                    default: cw_r.halt = 1'b1;
                endcase
            end
            default: cw_r.halt = 1'b1; // Unknown opcode.
        endcase

        // Only shifts carry funct7 bit 5 in the immediate form.
        if (opcode == OP_IMM && f3 != F3_SLL && f3 != F3_SRL_SRA) begin
            cw_r.alu_mode = alu_mode_t'({1'b0, f3});
        end

        // x0 never creates a dependency.
        cw_r.ra_used  = cw_r.ra_used && (rs1 != '0);
        cw_r.rb_used  = cw_r.rb_used && (rs2 != '0);
        cw_r.wb_valid = (cw_r.wb_src != WB_SRC_X) && (rd != '0);
    end

    assign cw = cw_r;

endmodule

/* src/imm_gen.sv */
`timescale 1ns/10ps

module imm_gen (
    input  isa_pkg::word_t instr,
    output isa_pkg::word_t imm
);

    import isa_pkg::*;

    opcode_t opcode;
    logic    sign;

    assign opcode = opcode_t'(instr[6:0]);
    assign sign   = instr[31]; // Every format takes its sign here.

    // ****************************************
    // Format select
    // ****************************************

    always_comb begin
        case (opcode)
            // I format.
            OP_IMM, OP_JALR, OP_LOAD, OP_SYSTEM: begin
                imm = {{20{sign}}, instr[31:20]};
            end
            OP_STORE: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            // B format, bit 0 implied.
            OP_BRANCH: begin
                imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            OP_LUI, OP_AUIPC: begin
                imm = {instr[31:12], 12'b0}; // Upper 20 bits.
            end
            // J format, bit 0 implied.
            OP_JAL: begin
                imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

/* src/isa_pkg.sv */
`include "core_settings.svh"

package isa_pkg;

    typedef logic [`XLEN-1:0]       word_t;
    typedef logic [`REG_ADDR_W-1:0] regaddr_t;

    // ****************************************
    // Instruction fields
    // ****************************************

    typedef enum logic [6:0] {
        OP_LOAD     = 7'b000_0011,
        OP_MISC_MEM = 7'b000_1111,
        OP_IMM      = 7'b001_0011,
        OP_AUIPC    = 7'b001_0111,
        OP_STORE    = 7'b010_0011,
        OP          = 7'b011_0011,
        OP_LUI      = 7'b011_0111,
        OP_BRANCH   = 7'b110_0011,
        OP_JALR     = 7'b110_0111,
        OP_JAL      = 7'b110_1111,
        OP_SYSTEM   = 7'b111_0011
    } opcode_t;

    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // Branch conditions.
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // Shifts keep funct7 bit 5 in immediate form.
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SRL_SRA = 3'b101;

    // System space.
    localparam funct3_t F3_PRIV   = 3'b000; // ecall, ebreak, mret, wfi.
    localparam funct3_t F3_CSRRW  = 3'b001;
    localparam funct3_t F3_CSRRS  = 3'b010;
    localparam funct3_t F3_CSRRC  = 3'b011;
    localparam funct3_t F3_CSRRWI = 3'b101;
    localparam funct3_t F3_CSRRSI = 3'b110;
    localparam funct3_t F3_CSRRCI = 3'b111;

    // ****************************************
    // Control selectors
    // ****************************************

    // Encoded as {funct7[5], funct3}.
    typedef enum logic [3:0] {
        ALU_ADD   = 4'b0000,
        ALU_SLL   = 4'b0001,
        ALU_SLT   = 4'b0010,
        ALU_SLTU  = 4'b0011,
        ALU_XOR   = 4'b0100,
        ALU_SRL   = 4'b0101,
        ALU_OR    = 4'b0110,
        ALU_AND   = 4'b0111,
        ALU_SUB   = 4'b1000,
        ALU_COPY1 = 4'b1010, // Pass operand 1, used by LUI.
        ALU_SRA   = 4'b1101,
        ALU_X     = 4'b1111
    } alu_mode_t;

    typedef enum logic [1:0] {ALU_OP1_X, ALU_OP1_RS1, ALU_OP1_IMMU} alu_op1_t;
    typedef enum logic [2:0] {
        ALU_OP2_X, ALU_OP2_RS2, ALU_OP2_IMMI, ALU_OP2_IMMS, ALU_OP2_PC
    } alu_op2_t;

    typedef enum logic [1:0] {PC_NEXT, PC_JUMP_REL, PC_JUMP_ABS, PC_BRANCH} pc_mode_t;
    typedef enum logic [1:0] {MA_X, MA_LOAD, MA_STORE} ma_mode_t;

    // Same bits as the load/store funct3.
    typedef enum logic [2:0] {
        MA_SIZE_B  = 3'b000,
        MA_SIZE_H  = 3'b001,
        MA_SIZE_W  = 3'b010,
        MA_SIZE_BU = 3'b100,
        MA_SIZE_HU = 3'b101,
        MA_SIZE_X  = 3'b111
    } ma_size_t;

    typedef enum logic [1:0] {WB_SRC_X, WB_SRC_ALU, WB_SRC_PC4, WB_SRC_MEM} wb_src_t;

    typedef struct packed {
        logic      halt;
        pc_mode_t  pc_mode;
        alu_op1_t  alu_op1;
        alu_op2_t  alu_op2;
        alu_mode_t alu_mode;
        ma_mode_t  ma_mode;
        ma_size_t  ma_size;
        wb_src_t   wb_src;
        logic      wb_valid;
        logic      ra_used;
        logic      rb_used;
        logic      csr_used;
        logic      priv;
    } control_word_t;

    // Decoded form of NOP_INSTR.
    localparam control_word_t CW_NOP = '{
        halt: 1'b0, pc_mode: PC_NEXT, alu_op1: ALU_OP1_RS1, alu_op2: ALU_OP2_IMMI,
        alu_mode: ALU_ADD, ma_mode: MA_X, ma_size: MA_SIZE_X, wb_src: WB_SRC_ALU,
        wb_valid: 1'b0, ra_used: 1'b0, rb_used: 1'b0, csr_used: 1'b0, priv: 1'b0
    };

endpackage

/* src/pipe_reg.sv */
`timescale 1ns/10ps

module pipe_reg #(
    parameter type      payload_t   = logic [31:0],
    parameter payload_t FLUSH_VALUE = '0
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    // Flush wins over stall.
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            out_valid <= 1'b0;
            out_data  <= FLUSH_VALUE;
        end else if (!stall) begin
            out_valid <= in_valid;
            out_data  <= in_data;
        end
        // Stalled, hold everything.
    end

endmodule

/* src/reg_file.sv */
`timescale 1ns/10ps
`include "core_settings.svh"

module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  isa_pkg::regaddr_t rs1_addr,
    input  isa_pkg::regaddr_t rs2_addr,
    output isa_pkg::word_t    rs1_data,
    output isa_pkg::word_t    rs2_data,
    input  logic              wb_en,
    input  isa_pkg::regaddr_t wb_addr,
    input  isa_pkg::word_t    wb_data
);

    import isa_pkg::*;

    word_t regs [1:`REG_COUNT-1]; // x0 has no storage.

    // Read with write-through from the writeback port.
    function automatic word_t read_port(regaddr_t addr);
        word_t data;
        if (addr == '0) begin
            data = '0;
        end else if (wb_en && wb_addr == addr) begin
            data = wb_data;
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    // ****************************************
    // Write port
    // ****************************************

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_addr != '0) begin
            regs[wb_addr] <= wb_data; // x0 writes dropped.
        end
    end

endmodule

/* src/stage_pkg.sv */
`include "core_settings.svh"

package stage_pkg;

    import isa_pkg::*;

    // ****************************************
    // Fetch to decode
    // ****************************************

    typedef struct packed {
        word_t pc;
        word_t instr;
    } fetch_pkt_t;

    localparam fetch_pkt_t FETCH_NOP = '{pc: '0, instr: `NOP_INSTR};

    // ****************************************
    // Decode to execute
    // ****************************************

    typedef struct packed {
        word_t         pc;
        control_word_t cw;
        word_t         rs1_data;
        word_t         rs2_data;
        word_t         imm;       // Already sign extended.
        regaddr_t      rd;
    } decode_pkt_t;

    // NOP after decode, all operands zero.
    localparam decode_pkt_t DECODE_NOP = '{
        pc: '0, cw: CW_NOP, rs1_data: '0, rs2_data: '0, imm: '0, rd: '0
    };

endpackage

/* verilog.f */
+incdir+src
src/isa_pkg.sv
src/stage_pkg.sv
src/decoder.sv
src/imm_gen.sv
src/reg_file.sv
src/pipe_reg.sv
src/decode_stage.sv
bench/decode_stage_asserts.sv
bench/decode_stage_tb.sv
